//--- source/backendPkg.sv
`default_nettype none

package backendPkg;

    localparam int XLEN      = 32;
    localparam int ARCH_REGS = 8;
    localparam int PHYS_REGS = 16;
    localparam int ROB_SIZE  = 8;
    localparam int IQ_SIZE   = 4;
    localparam int MUL_LAT   = 3;

    // rv32 major opcodes and funct7 values in use.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;
    localparam logic [6:0] F7_MULDIV  = 7'b0000001;

    typedef logic [XLEN-1:0]              data_t;
    typedef logic [31:0]                  inst_t;
    typedef logic [$clog2(ARCH_REGS)-1:0] archReg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] physReg_t;
    typedef logic [$clog2(ROB_SIZE)-1:0]  robIdx_t;

    // nop marks an unsupported encoding.
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MUL,
        OP_NOP
    } aluOp_t;

endpackage

`default_nettype wire

//--- source/backendIfs.sv
`default_nettype none

interface renameIssueIf import backendPkg::*; ();
    logic     valid;
    aluOp_t   op;
    logic     useImm;
    data_t    imm;
    physReg_t src1;
    physReg_t src2;
    logic     src1Zero;
    logic     src2Zero;
    physReg_t dst;
    logic     we;
    archReg_t archRd;
    physReg_t prevDst;
    robIdx_t  robIdx;
    logic     stall;

    modport source (
        output valid, op, useImm, imm, src1, src2, src1Zero, src2Zero,
        output dst, we, archRd, prevDst,
        input  stall
    );

    modport issue (
        input  valid, op, useImm, imm, src1, src2, src1Zero, src2Zero,
        input  dst, we, robIdx,
        output stall
    );

    modport rob (
        input  valid, we, archRd, prevDst,
        output robIdx
    );
endinterface

interface writeBackIf import backendPkg::*; ();
    logic     en;
    physReg_t dst;
    logic     we;
    robIdx_t  robIdx;
    data_t    data;

    modport source (output en, dst, we, robIdx, data);
    modport rob (input en, robIdx, data);
    modport monitor (input en, dst, we);
endinterface

`default_nettype wire

//--- source/renameUnit.sv
`default_nettype none

module renameUnit import backendPkg::*; (
    input  logic         clk,
    input  logic         arstN,
    input  logic         instValid,
    input  inst_t        instWord,
    renameIssueIf.source rnOut,
    input  logic         freeEn,
    input  physReg_t     freeReg,
    output logic         freeEmpty
);
    localparam int FREE_SIZE = PHYS_REGS - ARCH_REGS;
    localparam int FPTR_W    = $clog2(FREE_SIZE);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       regsOk;
    aluOp_t     decOp;
    logic       decUseImm;
    logic       decWe;
    logic       accept;
    logic       pop;

    physReg_t          rat      [ARCH_REGS];
    physReg_t          freeList [FREE_SIZE];
    logic [FPTR_W-1:0] freeHead;
    logic [FPTR_W-1:0] freeTail;
    logic [FPTR_W:0]   freeCount;

    // only x0..x7 exist here.
    function automatic logic inRange(input logic [4:0] r);
        return r[4:$bits(archReg_t)] == '0;
    endfunction

    assign opcode = instWord[6:0];
    assign rd     = instWord[11:7];
    assign funct3 = instWord[14:12];
    assign rs1    = instWord[19:15];
    assign rs2    = instWord[24:20];
    assign funct7 = instWord[31:25];

    always_comb begin
        decOp     = OP_NOP;
        decUseImm = 1'b0;
        regsOk    = inRange(rd) && inRange(rs1);
        if (opcode == OPC_OP) begin
            regsOk = regsOk && inRange(rs2);
            case ({funct7, funct3})
                {F7_BASE, 3'b000}:   decOp = OP_ADD;
                {F7_ALT, 3'b000}:    decOp = OP_SUB;
                {F7_BASE, 3'b111}:   decOp = OP_AND;
                {F7_BASE, 3'b110}:   decOp = OP_OR;
                {F7_BASE, 3'b100}:   decOp = OP_XOR;
                {F7_MULDIV, 3'b000}: decOp = OP_MUL;
                default:             decOp = OP_NOP;
            endcase
        end else if (opcode == OPC_OP_IMM && funct3 == 3'b000) begin
            decOp     = OP_ADD;
            decUseImm = 1'b1;
        end
        if (!regsOk) begin
            decOp     = OP_NOP;
            decUseImm = 1'b0;
        end
    end

    assign decWe     = (decOp != OP_NOP) && (rd != 5'd0);
    assign accept    = instValid && !rnOut.stall;
    assign pop       = accept && decWe;
    assign freeEmpty = (freeCount == '0) && instValid && decWe;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                rat[i] <= physReg_t'(i);
            end
            // physical regs above the identity map start free.
            for (int i = 0; i < FREE_SIZE; i++) begin
                freeList[i] <= physReg_t'(ARCH_REGS + i);
            end
            freeHead    <= '0;
            freeTail    <= '0;
            freeCount   <= (FPTR_W + 1)'(FREE_SIZE);
            rnOut.valid <= 1'b0;
        end else begin
            rnOut.valid <= accept;
            if (pop) begin
                rat[archReg_t'(rd)] <= freeList[freeHead];
                freeHead            <= freeHead + 1'b1;
            end
            if (freeEn) begin
                freeList[freeTail] <= freeReg;
                freeTail           <= freeTail + 1'b1;
            end
            freeCount <= freeCount + (FPTR_W + 1)'(freeEn) - (FPTR_W + 1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rnOut.op       <= decOp;
            rnOut.useImm   <= decUseImm;
            rnOut.imm      <= {{20{instWord[31]}}, instWord[31:20]};
            rnOut.src1     <= rat[archReg_t'(rs1)];
            rnOut.src2     <= rat[archReg_t'(rs2)];
            rnOut.src1Zero <= (rs1 == 5'd0) || (decOp == OP_NOP);
            rnOut.src2Zero <= decUseImm || (rs2 == 5'd0) || (decOp == OP_NOP);
            rnOut.dst      <= freeList[freeHead];
            rnOut.we       <= decWe;
            rnOut.archRd   <= archReg_t'(rd);
            rnOut.prevDst  <= rat[archReg_t'(rd)];
        end
    end

endmodule

`default_nettype wire

//--- source/reorderBuffer.sv
`default_nettype none

module reorderBuffer import backendPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    renameIssueIf.rob rnIn,
    writeBackIf.rob   wbIn,
    output logic      robFull,
    output logic      commitEn,
    output logic      commitWe,
    output archReg_t  commitRd,
    output data_t     commitData,
    output logic      freeEn,
    output physReg_t  freeReg
);
    localparam int CNT_W = $clog2(ROB_SIZE) + 1;

    logic     done    [ROB_SIZE];
    logic     entWe   [ROB_SIZE];
    archReg_t entRd   [ROB_SIZE];
    physReg_t entPrev [ROB_SIZE];
    data_t    entData [ROB_SIZE];

    robIdx_t          head;
    robIdx_t          tail;
    logic [CNT_W-1:0] count;

    assign rnIn.robIdx = tail;

    // the renamed instruction still in flight counts as taken.
    assign robFull = (count + CNT_W'(rnIn.valid)) >= CNT_W'(ROB_SIZE);

    assign commitEn   = (count != '0) && done[head];
    assign commitWe   = entWe[head];
    assign commitRd   = entRd[head];
    assign commitData = entData[head];

    // old mapping of a written reg goes back to the free list.
    assign freeEn  = commitEn && entWe[head];
    assign freeReg = entPrev[head];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < ROB_SIZE; i++) begin
                done[i] <= 1'b0;
            end
        end else begin
            if (rnIn.valid) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (wbIn.en) begin
                done[wbIn.robIdx] <= 1'b1;
            end
            if (commitEn) begin
                head <= head + 1'b1;
            end
            count <= count + CNT_W'(rnIn.valid) - CNT_W'(commitEn);
        end
    end

    always_ff @(posedge clk) begin
        if (rnIn.valid) begin
            entWe[tail]   <= rnIn.we;
            entRd[tail]   <= rnIn.archRd;
            entPrev[tail] <= rnIn.prevDst;
        end
        if (wbIn.en) begin
            entData[wbIn.robIdx] <= wbIn.data;
        end
    end

endmodule

`default_nettype wire

//--- source/issueCtrl.sv
`default_nettype none

module issueCtrl import backendPkg::*; (
    input  logic         clk,
    input  logic         arstN,
    renameIssueIf.issue  rnIn,
    writeBackIf.monitor  wbIn,
    input  logic         robFull,
    input  logic         freeEmpty,
    output logic         stall,
    output logic         issueEn,
    output aluOp_t       issueOp,
    output physReg_t     issueSrc1,
    output physReg_t     issueSrc2,
    output logic         issueSrc1Zero,
    output logic         issueSrc2Zero,
    output logic         issueUseImm,
    output data_t        issueImm,
    output physReg_t     issueDst,
    output logic         issueWe,
    output robIdx_t      issueRob
);
    localparam int PTR_W = $clog2(IQ_SIZE);
    localparam int CNT_W = PTR_W + 1;

    typedef enum logic {
        ST_IDLE,
        ST_DRAIN
    } iqState_t;

    aluOp_t   qOp     [IQ_SIZE];
    logic     qUseImm [IQ_SIZE];
    data_t    qImm    [IQ_SIZE];
    physReg_t qSrc1   [IQ_SIZE];
    physReg_t qSrc2   [IQ_SIZE];
    logic     qS1Zero [IQ_SIZE];
    logic     qS2Zero [IQ_SIZE];
    physReg_t qDst    [IQ_SIZE];
    logic     qWe     [IQ_SIZE];
    robIdx_t  qRob    [IQ_SIZE];

    logic [PTR_W-1:0]     head;
    logic [PTR_W-1:0]     tail;
    logic [CNT_W-1:0]     count;
    logic [CNT_W-1:0]     countNext;
    logic [PHYS_REGS-1:0] ready;
    logic [MUL_LAT-1:0]   resv;
    logic [MUL_LAT-1:0]   resvNext;
    iqState_t             state;
    iqState_t             stateNext;
    logic                 iqFull;
    logic                 headMul;
    logic                 srcReady;
    logic                 slotFree;

    assign iqFull     = (count + CNT_W'(rnIn.valid)) >= CNT_W'(IQ_SIZE);
    assign stall      = robFull || iqFull || freeEmpty;
    assign rnIn.stall = stall;

    assign issueOp       = qOp[head];
    assign issueUseImm   = qUseImm[head];
    assign issueImm      = qImm[head];
    assign issueSrc1     = qSrc1[head];
    assign issueSrc2     = qSrc2[head];
    assign issueSrc1Zero = qS1Zero[head];
    assign issueSrc2Zero = qS2Zero[head];
    assign issueDst      = qDst[head];
    assign issueWe       = qWe[head];
    assign issueRob      = qRob[head];

    assign headMul  = (issueOp == OP_MUL);
    assign srcReady = (issueSrc1Zero || ready[issueSrc1]) && (issueSrc2Zero || ready[issueSrc2]);
    // resv[i] set means a writeback lands i cycles from now.
    assign slotFree = headMul || !resv[1];
    assign issueEn  = (state == ST_DRAIN) && (count != '0) && srcReady && slotFree;

    assign countNext = count + CNT_W'(rnIn.valid) - CNT_W'(issueEn);

    always_comb begin
        resvNext    = {issueEn && headMul, resv[MUL_LAT-1:1]};
        resvNext[0] = resvNext[0] | (issueEn && !headMul);
    end

    always_comb begin
        stateNext = state;
        case (state)
            ST_IDLE: begin
                if (rnIn.valid) begin
                    stateNext = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                // back to idle once the queue and pipes are empty.
                if (count == '0 && !rnIn.valid && resv == '0) begin
                    stateNext = ST_IDLE;
                end
            end
            default: stateNext = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            ready <= '1;
            resv  <= '0;
            state <= ST_IDLE;
        end else begin
            state <= stateNext;
            resv  <= resvNext;
            count <= countNext;
            if (rnIn.valid) begin
                tail <= tail + 1'b1;
            end
            if (issueEn) begin
                head <= head + 1'b1;
            end
            if (wbIn.en && wbIn.we) begin
                ready[wbIn.dst] <= 1'b1;
            end
            if (rnIn.valid && rnIn.we) begin
                ready[rnIn.dst] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rnIn.valid) begin
            qOp[tail]     <= rnIn.op;
            qUseImm[tail] <= rnIn.useImm;
            qImm[tail]    <= rnIn.imm;
            qSrc1[tail]   <= rnIn.src1;
            qSrc2[tail]   <= rnIn.src2;
            qS1Zero[tail] <= rnIn.src1Zero;
            qS2Zero[tail] <= rnIn.src2Zero;
            qDst[tail]    <= rnIn.dst;
            qWe[tail]     <= rnIn.we;
            qRob[tail]    <= rnIn.robIdx;
        end
    end

endmodule

`default_nettype wire

//--- source/execUnit.sv
`default_nettype none

module execUnit import backendPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        issueEn,
    input  aluOp_t      issueOp,
    input  physReg_t    issueSrc1,
    input  physReg_t    issueSrc2,
    input  logic        issueSrc1Zero,
    input  logic        issueSrc2Zero,
    input  logic        issueUseImm,
    input  data_t       issueImm,
    input  physReg_t    issueDst,
    input  logic        issueWe,
    input  robIdx_t     issueRob,
    writeBackIf.source  wbOut
);
    localparam int HALF = XLEN / 2;

    data_t    regFile [PHYS_REGS];
    data_t    opA;
    data_t    opB;
    data_t    aluRes;
    logic     isMul;

    logic     aluValid;
    physReg_t aluDst;
    logic     aluWe;
    robIdx_t  aluRob;
    data_t    aluData;

    logic     mulValid [MUL_LAT];
    physReg_t mulDst   [MUL_LAT];
    logic     mulWe    [MUL_LAT];
    robIdx_t  mulRob   [MUL_LAT];
    data_t    mulA;
    data_t    mulB;
    data_t    mulLo;
    data_t    mulHi;
    data_t    mulProd;

    assign isMul = (issueOp == OP_MUL);
    assign opA   = issueSrc1Zero ? '0 : regFile[issueSrc1];
    assign opB   = issueUseImm ? issueImm : (issueSrc2Zero ? '0 : regFile[issueSrc2]);

    always_comb begin
        case (issueOp)
            OP_ADD:  aluRes = opA + opB;
            OP_SUB:  aluRes = opA - opB;
            OP_AND:  aluRes = opA & opB;
            OP_OR:   aluRes = opA | opB;
            OP_XOR:  aluRes = opA ^ opB;
            default: aluRes = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            aluValid <= 1'b0;
            for (int i = 0; i < MUL_LAT; i++) begin
                mulValid[i] <= 1'b0;
            end
            for (int i = 0; i < PHYS_REGS; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            aluValid    <= issueEn && !isMul;
            mulValid[0] <= issueEn && isMul;
            for (int i = 1; i < MUL_LAT; i++) begin
                mulValid[i] <= mulValid[i-1];
            end
            if (wbOut.en && wbOut.we) begin
                regFile[wbOut.dst] <= wbOut.data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issueEn && !isMul) begin
            aluDst  <= issueDst;
            aluWe   <= issueWe;
            aluRob  <= issueRob;
            aluData <= aluRes;
        end
        if (issueEn && isMul) begin
            mulDst[0] <= issueDst;
            mulWe[0]  <= issueWe;
            mulRob[0] <= issueRob;
            mulA      <= opA;
            mulB      <= opB;
        end
        for (int i = 1; i < MUL_LAT; i++) begin
            mulDst[i] <= mulDst[i-1];
            mulWe[i]  <= mulWe[i-1];
            mulRob[i] <= mulRob[i-1];
        end
        // split multiplier on the halves of b, summed in the last stage.
        mulLo   <= mulA * {{HALF{1'b0}}, mulB[HALF-1:0]};
        mulHi   <= mulA * {{HALF{1'b0}}, mulB[XLEN-1:HALF]};
        mulProd <= mulLo + {mulHi[HALF-1:0], {HALF{1'b0}}};
    end

    // issue reserves the slot, so the two sources never overlap.
    always_comb begin
        if (mulValid[MUL_LAT-1]) begin
            wbOut.en     = 1'b1;
            wbOut.dst    = mulDst[MUL_LAT-1];
            wbOut.we     = mulWe[MUL_LAT-1];
            wbOut.robIdx = mulRob[MUL_LAT-1];
            wbOut.data   = mulProd;
        end else begin
            wbOut.en     = aluValid;
            wbOut.dst    = aluDst;
            wbOut.we     = aluWe;
            wbOut.robIdx = aluRob;
            wbOut.data   = aluData;
        end
    end

endmodule

`default_nettype wire

//--- source/backendTop.sv
`default_nettype none

module backendTop import backendPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     instValid,
    input  inst_t    instWord,
    output logic     stall,
    output logic     commitEn,
    output logic     commitWe,
    output archReg_t commitRd,
    output data_t    commitData
);
    renameIssueIf rnIf();
    writeBackIf   wbIf();

    logic     robFull;
    logic     freeEmpty;
    logic     freeEn;
    physReg_t freeReg;

    logic     issueEn;
    aluOp_t   issueOp;
    physReg_t issueSrc1;
    physReg_t issueSrc2;
    logic     issueSrc1Zero;
    logic     issueSrc2Zero;
    logic     issueUseImm;
    data_t    issueImm;
    physReg_t issueDst;
    logic     issueWe;
    robIdx_t  issueRob;

    renameUnit renameUnit_i (
        .clk       (clk),
        .arstN     (arstN),
        .instValid (instValid),
        .instWord  (instWord),
        .rnOut     (rnIf),
        .freeEn    (freeEn),
        .freeReg   (freeReg),
        .freeEmpty (freeEmpty)
    );

    reorderBuffer reorderBuffer_i (
        .clk        (clk),
        .arstN      (arstN),
        .rnIn       (rnIf),
        .wbIn       (wbIf),
        .robFull    (robFull),
        .commitEn   (commitEn),
        .commitWe   (commitWe),
        .commitRd   (commitRd),
        .commitData (commitData),
        .freeEn     (freeEn),
        .freeReg    (freeReg)
    );

    issueCtrl issueCtrl_i (
        .clk           (clk),
        .arstN         (arstN),
        .rnIn          (rnIf),
        .wbIn          (wbIf),
        .robFull       (robFull),
        .freeEmpty     (freeEmpty),
        .stall         (stall),
        .issueEn       (issueEn),
        .issueOp       (issueOp),
        .issueSrc1     (issueSrc1),
        .issueSrc2     (issueSrc2),
        .issueSrc1Zero (issueSrc1Zero),
        .issueSrc2Zero (issueSrc2Zero),
        .issueUseImm   (issueUseImm),
        .issueImm      (issueImm),
        .issueDst      (issueDst),
        .issueWe       (issueWe),
        .issueRob      (issueRob)
    );

    execUnit execUnit_i (
        .clk           (clk),
        .arstN         (arstN),
        .issueEn       (issueEn),
        .issueOp       (issueOp),
        .issueSrc1     (issueSrc1),
        .issueSrc2     (issueSrc2),
        .issueSrc1Zero (issueSrc1Zero),
        .issueSrc2Zero (issueSrc2Zero),
        .issueUseImm   (issueUseImm),
        .issueImm      (issueImm),
        .issueDst      (issueDst),
        .issueWe       (issueWe),
        .issueRob      (issueRob),
        .wbOut         (wbIf)
    );

endmodule

`default_nettype wire

//--- dv/backend_properties.sv
`default_nettype none

module backendProperties import backendPkg::*; (
    input logic     clk,
    input logic     arstN,
    input logic     instValid,
    input inst_t    instWord,
    input logic     stall,
    input logic     commitEn,
    input logic     commitWe,
    input archReg_t commitRd
);

    int assertFails = 0;

    // fetch holds its word while stalled.
    holdWhileStalled: assert property (
        @(posedge clk) disable iff (!arstN)
        (instValid && stall) |=> $stable(instWord)
    ) else begin
        $error("instWord changed while stall was high");
        assertFails++;
    end

    noCommitInReset: assert property (
        @(posedge clk) !arstN |-> !commitEn
    ) else begin
        $error("commitEn high during reset");
        assertFails++;
    end

    noWriteToX0: assert property (
        @(posedge clk) disable iff (!arstN)
        (commitEn && commitWe) |-> (commitRd != '0)
    ) else begin
        $error("commit writes x0");
        assertFails++;
    end

endmodule

bind backendTop backendProperties props_i (
    .clk       (clk),
    .arstN     (arstN),
    .instValid (instValid),
    .instWord  (instWord),
    .stall     (stall),
    .commitEn  (commitEn),
    .commitWe  (commitWe),
    .commitRd  (commitRd)
);

`default_nettype wire

//--- dv/backendTb.sv
`default_nettype none

module backendTb import backendPkg::*; ();

    logic     clk;
    logic     arstN;
    logic     instValid;
    inst_t    instWord;
    logic     stall;
    logic     commitEn;
    logic     commitWe;
    archReg_t commitRd;
    data_t    commitData;

    inst_t       instTab [$];
    logic        weTab   [$];
    data_t       arch    [ARCH_REGS];
    int          tabLen;
    int          burstFirst;
    int          errCount;
    int          commitCount;
    integer      seed;
    logic [31:0] gapDraw;
    bit          tableReady;
    bit          sawStall;

    backendTop dut_i (
        .clk        (clk),
        .arstN      (arstN),
        .instValid  (instValid),
        .instWord   (instWord),
        .stall      (stall),
        .commitEn   (commitEn),
        .commitWe   (commitWe),
        .commitRd   (commitRd),
        .commitData (commitData)
    );

    // period 8.
    always #4 clk = ~clk;

    function automatic inst_t encodeR(input logic [6:0] f7, input logic [2:0] f3,
                                      input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic inst_t encodeAddi(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
    endfunction

    // reference result from the architectural state, in program order.
    function automatic data_t goldenValue(input inst_t w);
        data_t a;
        data_t b;
        a = arch[w[17:15]];
        b = arch[w[22:20]];
        if (w[6:0] == 7'b0010011) begin
            return a + {{20{w[31]}}, w[31:20]};
        end
        case ({w[31:25], w[14:12]})
            {7'h00, 3'b000}: return a + b;
            {7'h20, 3'b000}: return a - b;
            {7'h00, 3'b111}: return a & b;
            {7'h00, 3'b110}: return a | b;
            {7'h00, 3'b100}: return a ^ b;
            {7'h01, 3'b000}: return a * b;
            default:         return '0;
        endcase
    endfunction

    task automatic addEntry(input inst_t w, input logic we);
        instTab.push_back(w);
        weTab.push_back(we);
    endtask

    task automatic fillTable();
        // plain alu ops, imm of both signs.
        addEntry(encodeAddi(1, 0, 100), 1'b1);
        addEntry(encodeAddi(2, 0, -37), 1'b1);
        addEntry(encodeR(7'h00, 3'b000, 3, 1, 2), 1'b1);
        addEntry(encodeR(7'h20, 3'b000, 4, 1, 2), 1'b1);
        addEntry(encodeR(7'h00, 3'b111, 5, 1, 2), 1'b1);
        addEntry(encodeR(7'h00, 3'b110, 6, 1, 2), 1'b1);
        addEntry(encodeR(7'h00, 3'b100, 7, 1, 2), 1'b1);
        addEntry(encodeAddi(3, 3, 2047), 1'b1);
        addEntry(encodeAddi(4, 4, -2048), 1'b1);
        // mul ahead of independent alu ops.
        addEntry(encodeR(7'h01, 3'b000, 5, 1, 2), 1'b1);
        addEntry(encodeR(7'h00, 3'b000, 6, 1, 1), 1'b1);
        addEntry(encodeR(7'h00, 3'b100, 7, 2, 1), 1'b1);
        addEntry(encodeR(7'h20, 3'b000, 3, 2, 1), 1'b1);
        // raw chain with reused destinations.
        addEntry(encodeR(7'h01, 3'b000, 1, 1, 2), 1'b1);
        addEntry(encodeR(7'h00, 3'b000, 2, 1, 1), 1'b1);
        addEntry(encodeR(7'h01, 3'b000, 3, 2, 1), 1'b1);
        addEntry(encodeR(7'h20, 3'b000, 1, 3, 2), 1'b1);
        addEntry(encodeAddi(1, 1, 5), 1'b1);
        // x0 targets and unsupported encodings.
        addEntry(encodeR(7'h00, 3'b000, 0, 1, 2), 1'b0);
        addEntry(encodeAddi(0, 0, 55), 1'b0);
        addEntry(32'h002081ff, 1'b0);
        addEntry(encodeR(7'h00, 3'b000, 9, 1, 2), 1'b0);
        addEntry(encodeR(7'h00, 3'b000, 5, 12, 2), 1'b0);
        addEntry(encodeR(7'h00, 3'b001, 6, 1, 2), 1'b0);
        addEntry(encodeR(7'h00, 3'b000, 6, 0, 3), 1'b1);
        addEntry(encodeAddi(7, 0, -1), 1'b1);
        // dependent mul burst, sent back to back.
        addEntry(encodeAddi(2, 0, 3), 1'b1);
        burstFirst = instTab.size();
        for (int k = 0; k < 10; k++) begin
            addEntry(encodeR(7'h01, 3'b000, 1, 1, 2), 1'b1);
        end
        addEntry(encodeR(7'h00, 3'b000, 4, 1, 0), 1'b1);
        tabLen = instTab.size();
    endtask

    task automatic checkCommit();
        inst_t    w;
        data_t    expVal;
        archReg_t expRd;
        if (!arstN) begin
            $display("a commit was seen while reset was asserted");
            errCount++;
        end else if (commitCount >= tabLen) begin
            $display("extra commit beyond the %0d instructions sent", tabLen);
            errCount++;
        end else begin
            w = instTab[commitCount];
            if (commitWe !== weTab[commitCount]) begin
                $display("Error at %0t: commit %0d commitWe %b, expected %b",
                         $time, commitCount, commitWe, weTab[commitCount]);
                errCount++;
            end else if (weTab[commitCount]) begin
                expRd  = w[9:7];
                expVal = goldenValue(w);
                if (commitRd !== expRd) begin
                    $display("Error at %0t: commit %0d rd x%0d, expected x%0d",
                             $time, commitCount, commitRd, expRd);
                    errCount++;
                end
                if (commitData !== expVal) begin
                    $display("Error at %0t: commit %0d data %h, expected %h",
                             $time, commitCount, commitData, expVal);
                    errCount++;
                end
                arch[expRd] = expVal;
            end
        end
        commitCount++;
    endtask

    task automatic reportAndFinish(input bit timedOut);
        $display("errors: %0d, assertion failures: %0d, commits: %0d of %0d",
                 errCount, dut_i.props_i.assertFails, commitCount, tabLen);
        if (errCount == 0 && dut_i.props_i.assertFails == 0 && !timedOut) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    always @(negedge clk) begin
        if (commitEn) begin
            checkCommit();
        end
    end

    initial begin
        clk         = 1'b0;
        arstN       = 1'b0;
        instValid   = 1'b0;
        instWord    = '0;
        errCount    = 0;
        commitCount = 0;
        seed        = 81;
        sawStall    = 1'b0;
        for (int r = 0; r < ARCH_REGS; r++) begin
            arch[r] = '0;
        end
        fillTable();
        tableReady = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        arstN = 1'b1;
        for (int i = 0; i < tabLen; i++) begin
            // random idle cycles, none inside the burst.
            if (i < burstFirst) begin
                gapDraw = $random(seed);
                while (gapDraw[1:0] == 2'b00) begin
                    instValid = 1'b0;
                    @(posedge clk);
                    #1;
                    gapDraw = $random(seed);
                end
            end
            instValid = 1'b1;
            instWord  = instTab[i];
            @(negedge clk);
            while (stall) begin
                if (i >= burstFirst) begin
                    sawStall = 1'b1;
                end
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        instValid = 1'b0;
        wait (commitCount == tabLen);
        // a few idle cycles to catch duplicate commits.
        repeat (10) @(posedge clk);
        if (!sawStall) begin
            $display("stall was never raised during the MUL burst");
            errCount++;
        end
        reportAndFinish(1'b0);
    end

    initial begin
        wait (tableReady);
        #((tabLen * 20 + 200) * 8);
        $display("timeout: only %0d of %0d instructions committed", commitCount, tabLen);
        reportAndFinish(1'b1);
    end

endmodule

`default_nettype wire

//--- compile.f
source/backendPkg.sv
source/backendIfs.sv
source/renameUnit.sv
source/reorderBuffer.sv
source/issueCtrl.sv
source/execUnit.sv
source/backendTop.sv
dv/backend_properties.sv
dv/backendTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= backendTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
SIMFLAGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)

run: build
	$(BUILD_DIR)/$(TOP) $(SIMFLAGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TB PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@! grep -q "^%Error" $(LOG) || (echo "assertion errors in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
